// ==== tb.f ====
+incdir+.
rv_pkg.sv
muldiv.sv
alu.sv
bcu.sv
ex_stage.sv
ex_ls_reg.sv
ex_top.sv
tb_ex_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ex_top -f tb.f -o tb_sim

# a failing check ends in $fatal, so the exit status carries the result
./obj_dir/tb_sim

// ==== tb_ex_model.svh ====
/*
 * Reference model of the execute stage for the testbench.
 * Included inside the testbench module, after the rv_pkg import.
 */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// rv32i integer operations
function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh = b[4:0];
    // sign bits shifted in from the top for sra
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (op)
        alu_add:    return a + b;
        alu_sub:    return a - b;
        alu_sll:    return a << sh;
        alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
        alu_xor:    return a ^ b;
        alu_srl:    return a >> sh;
        alu_sra:    return (a >> sh) | fill;
        alu_or:     return a | b;
        alu_and:    return a & b;
        alu_pass_b: return b;
        default:    return 32'h0;
    endcase
endfunction

// m extension with the riscv rules for zero divisor and overflow
function automatic word_t model_md(md_op_e op, word_t a, word_t b);
    longint      sa;
    longint      sb;
    longint      ua;
    longint      ub;
    logic [63:0] p;
    logic        ovf;
    sa  = longint'($signed(a));
    sb  = longint'($signed(b));
    ua  = longint'({32'h0, a});
    ub  = longint'({32'h0, b});
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        md_mul: begin
            p = sa * sb;
            return p[31:0];
        end
        md_mulh: begin
            p = sa * sb;
            return p[63:32];
        end
        md_mulhsu: begin
            p = sa * ub;
            return p[63:32];
        end
        md_mulhu: begin
            p = ua * ub;
            return p[63:32];
        end
        md_div:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : word_t'(sa / sb));
        md_divu: return (b == 0) ? 32'hffff_ffff : a / b;
        md_rem:  return (b == 0) ? a : (ovf ? 32'h0 : word_t'(sa % sb));
        default: return (b == 0) ? a : a % b;
    endcase
endfunction

function automatic word_t pick_operand(fw_sel_e sel, word_t rf, fw_bus_t f);
    case (sel)
        fw_ex:   return f.ex;
        fw_ls:   return f.ls;
        fw_wb:   return f.wb;
        default: return rf;
    endcase
endfunction

// beq bne blt bge bltu bgeu
function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return !($signed(a) < $signed(b));
        3'd6:    return a < b;
        3'd7:    return !(a < b);
        default: return 1'b0;
    endcase
endfunction

// whole stage result for one instruction
function automatic ex_res_t predict_result(ex_ctrl_t c, ex_in_t d, fw_bus_t f);
    ex_res_t r;
    word_t   rs1;
    word_t   rs2;
    word_t   src1;
    word_t   src2;
    word_t   sum;
    logic    taken;
    rs1  = pick_operand(c.rs1_sel, d.rs1, f);
    rs2  = pick_operand(c.rs2_sel, d.rs2, f);
    src1 = c.src1_pc ? d.pc : rs1;
    case (c.src2_sel)
        src2_imm:  src2 = d.imm;
        src2_zero: src2 = 32'h0;
        src2_four: src2 = 32'd4;
        default:   src2 = rs2;
    endcase
    r.alu_res = c.md_en ? model_md(c.md_op, src1, src2) : model_alu(c.alu_op, src1, src2);
    r.rs2_fwd = rs2;
    taken     = c.is_brc && branch_taken(d.instr[14:12], rs1, rs2);
    r.is_jump = c.is_jal || c.is_jalr || taken;
    sum       = rs1 + d.imm;
    if (c.is_jalr) begin
        r.pc_next = {sum[31:1], 1'b0};
    end else if (c.is_jal || taken) begin
        r.pc_next = d.pc + d.imm;
    end else begin
        r.pc_next = d.pc + 32'd4;
    end
    // load and store opcodes from the isa encoding
    r.wren = (d.instr[6:2] == 5'b01000);
    r.rden = (d.instr[6:0] == 7'b0000011);
    return r;
endfunction

`endif

// ==== tb_ex_top.sv ====
/*
 * Testbench for the execute stage top level.
 * Issues random instructions, waits for each to reach the EX/LS
 * register and checks the result against the included model.
 */
`timescale 1ns/10ps

module tb_ex_top
    import rv_pkg::*;
();

    localparam int wait_limit = 100;

    logic     clk;
    logic     arst_n;
    logic     ex_valid;
    ex_ctrl_t ex_ctrl;
    ex_in_t   ex_in;
    fw_bus_t  fw;
    logic     ls_addr_ok;
    logic     ex_stall;
    logic     ls_valid;
    ex_res_t  ls_res;

    `include "tb_ex_model.svh"

    ex_top UUT (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .ex_valid_i   (ex_valid),
        .ex_ctrl_i    (ex_ctrl),
        .ex_in_i      (ex_in),
        .fw_i         (fw),
        .ls_addr_ok_i (ls_addr_ok),
        .ex_stall_o   (ex_stall),
        .ls_valid_o   (ls_valid),
        .ls_res_o     (ls_res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("error at %0t: %s got %b expected %b", $time, what, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_res(input ex_res_t got, input ex_res_t want, input string what);
        if (got !== want) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("The run timed out while waiting for %s.", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // corner values now and then for overflow and zero cases
    function automatic word_t rand_word();
        case ($urandom_range(0, 7))
            0:       return 32'h0;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            default: return $urandom();
        endcase
    endfunction

    function automatic ex_ctrl_t rand_ctrl();
        ex_ctrl_t c;
        c          = '0;
        c.alu_op   = alu_op_e'(5'($urandom_range(0, 10)));
        c.src1_pc  = 1'($urandom_range(0, 1));
        c.src2_sel = src2_sel_e'(2'($urandom_range(0, 3)));
        c.rs1_sel  = fw_sel_e'(2'($urandom_range(0, 3)));
        c.rs2_sel  = fw_sel_e'(2'($urandom_range(0, 3)));
        c.md_op    = md_op_e'(3'($urandom_range(0, 7)));
        return c;
    endfunction

    function automatic ex_in_t rand_in();
        ex_in_t d;
        // word aligned pc
        d.pc    = $urandom() & 32'hffff_fffc;
        d.instr = $urandom();
        d.rs1   = rand_word();
        d.rs2   = rand_word();
        d.imm   = rand_word();
        return d;
    endfunction

    function automatic fw_bus_t rand_fw();
        fw_bus_t f;
        f.ex = rand_word();
        f.ls = rand_word();
        f.wb = rand_word();
        return f;
    endfunction

    // one instruction from issue to the ex/ls register
    // hold keeps ls_addr_ok low for that many cycles first
    task automatic run_instr(input ex_ctrl_t c, input ex_in_t d, input fw_bus_t f,
                             input int hold);
        ex_res_t want;
        ex_res_t snap_res;
        logic    snap_valid;
        int      stall_cnt;
        int      want_stall;
        int      tmo;
        want       = predict_result(c, d, f);
        want_stall = hold;
        if (c.md_en && (c.md_op inside {md_div, md_divu, md_rem, md_remu})) begin
            // start cycle plus 32 iterations
            want_stall = hold + 33;
        end
        stall_cnt = 0;
        @(posedge clk);
        ex_valid <= 1'b1;
        ex_ctrl  <= c;
        ex_in    <= d;
        fw       <= f;
        if (hold > 0) begin
            ls_addr_ok <= 1'b0;
        end
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_flag(ex_stall, 1'b1, "stall under back-pressure");
            if (i == 0) begin
                // the issue edge itself still loaded the register
                snap_res   = ls_res;
                snap_valid = ls_valid;
            end else begin
                check_flag(ls_valid, snap_valid, "ls_valid_o held");
                check_res(ls_res, snap_res, "ls_res_o held");
            end
            stall_cnt++;
        end
        if (hold > 0) begin
            @(posedge clk);
            ls_addr_ok <= 1'b1;
        end
        // wait for acceptance
        tmo = 0;
        @(negedge clk);
        while (ex_stall) begin
            stall_cnt++;
            tmo++;
            if (tmo > wait_limit) begin
                stop_on_timeout("the stall to fall");
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        ex_valid <= 1'b0;
        tmo = 0;
        @(negedge clk);
        while (!ls_valid) begin
            tmo++;
            if (tmo > wait_limit) begin
                stop_on_timeout("ls_valid_o");
            end else begin
                @(negedge clk);
            end
        end
        check_word(word_t'(stall_cnt), word_t'(want_stall), "stall cycles");
        check_word(ls_res.alu_res, want.alu_res, "alu_res");
        check_word(ls_res.rs2_fwd, want.rs2_fwd, "rs2_fwd");
        check_word(ls_res.pc_next, want.pc_next, "pc_next");
        check_flag(ls_res.is_jump, want.is_jump, "is_jump");
        check_flag(ls_res.rden, want.rden, "rden");
        check_flag(ls_res.wren, want.wren, "wren");
    endtask

    initial begin
        ex_ctrl_t c;
        ex_in_t   d;
        int       pick;
        int       seed_ret;
        seed_ret   = $urandom(32'h39f0f7a6);
        arst_n     = 1'b0;
        ex_valid   = 1'b0;
        ex_ctrl    = '0;
        ex_in      = '0;
        fw         = '0;
        ls_addr_ok = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag(ls_valid, 1'b0, "ls_valid_o after reset");
        check_flag(ex_stall, 1'b0, "ex_stall_o after reset");
        check_res(ls_res, '0, "ls_res_o after reset");

        // plain alu ops on register file operands
        for (int n = 0; n < 60; n++) begin
            c         = rand_ctrl();
            c.rs1_sel = fw_rf;
            c.rs2_sel = fw_rf;
            run_instr(c, rand_in(), rand_fw(), 0);
        end
        // forwarding from ex, ls and wb
        for (int n = 0; n < 40; n++) begin
            run_instr(rand_ctrl(), rand_in(), rand_fw(), 0);
        end
        // branches and jumps
        for (int n = 0; n < 60; n++) begin
            c    = rand_ctrl();
            d    = rand_in();
            pick = $urandom_range(0, 3);
            c.is_jal  = (pick == 0);
            c.is_jalr = (pick == 1);
            c.is_brc  = (pick >= 2);
            if ($urandom_range(0, 3) == 0) begin
                // equal operands so beq/bge also get taken
                c.rs1_sel = fw_rf;
                c.rs2_sel = fw_rf;
                d.rs2     = d.rs1;
            end
            run_instr(c, d, rand_fw(), 0);
        end
        // multiply and divide
        for (int n = 0; n < 40; n++) begin
            c       = rand_ctrl();
            d       = rand_in();
            c.md_en = 1'b1;
            pick    = $urandom_range(0, 3);
            if (pick < 2) begin
                c.src1_pc  = 1'b0;
                c.src2_sel = src2_rs2;
                c.rs1_sel  = fw_rf;
                c.rs2_sel  = fw_rf;
                d.rs2      = 32'h0;
            end
            if (pick == 1) begin
                // signed overflow
                d.rs1 = 32'h8000_0000;
                d.rs2 = 32'hffff_ffff;
            end
            run_instr(c, d, rand_fw(), 0);
        end
        // loads and stores
        for (int n = 0; n < 30; n++) begin
            d = rand_in();
            case ($urandom_range(0, 3))
                0:       d.instr[6:0] = {op_load, 2'b11};
                1:       d.instr[6:0] = {op_store, 2'b11};
                2:       d.instr[6:0] = {op_load, 2'b01};
                default: d.instr[6:0] = 7'($urandom());
            endcase
            run_instr(rand_ctrl(), d, rand_fw(), 0);
        end
        // back-pressure from load/store
        for (int n = 0; n < 20; n++) begin
            c       = rand_ctrl();
            c.md_en = 1'($urandom_range(0, 1));
            run_instr(c, rand_in(), rand_fw(), $urandom_range(1, 6));
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== ex_top.sv ====
/*
 * Top of the execute stage.
 * Ties the combinational execute datapath to the EX/LS register.
 */
`timescale 1ns/10ps

module ex_top
    import rv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     ex_valid_i,
    input  ex_ctrl_t ex_ctrl_i,
    input  ex_in_t   ex_in_i,
    input  fw_bus_t  fw_i,
    input  logic     ls_addr_ok_i,
    output logic     ex_stall_o,
    output logic     ls_valid_o,
    output ex_res_t  ls_res_o
);

    ex_res_t ex_res;
    logic    ex_stall;

    ex_stage u_ex_stage (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (ex_valid_i),
        .ctrl_i       (ex_ctrl_i),
        .in_i         (ex_in_i),
        .fw_i         (fw_i),
        .ls_addr_ok_i (ls_addr_ok_i),
        .res_o        (ex_res),
        .stall_o      (ex_stall)
    );

    // valid goes straight to the boundary register
    ex_ls_reg u_ex_ls_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_valid_i),
        .stall_i  (ex_stall),
        .res_i    (ex_res),
        .valid_o  (ls_valid_o),
        .res_o    (ls_res_o)
    );

    assign ex_stall_o = ex_stall;

endmodule

// ==== ex_ls_reg.sv ====
/*
 * Pipeline register between execute and load/store.
 * Captures the execute result and valid level; holds both on stall.
 */
`timescale 1ns/10ps

module ex_ls_reg
    import rv_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    valid_i,
    input  logic    stall_i,
    input  ex_res_t res_i,
    output logic    valid_o,
    output ex_res_t res_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            res_o   <= '0;
        end else if (!stall_i) begin
            // advance only when the stage is free
            valid_o <= valid_i;
            res_o   <= res_i;
        end
    end

endmodule

// ==== ex_stage.sv ====
/*
 * Execute stage datapath.
 * Resolves operand forwarding, selects ALU sources, runs ALU and
 * branch unit, flags loads/stores and raises the stage stall.
 */
`timescale 1ns/10ps

module ex_stage
    import rv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  ex_ctrl_t ctrl_i,
    input  ex_in_t   in_i,
    input  fw_bus_t  fw_i,
    input  logic     ls_addr_ok_i,
    output ex_res_t  res_o,
    output logic     stall_o
);

    word_t rs1;
    word_t rs2;
    word_t src1;
    word_t src2;
    logic  md_busy;
    logic  div_start;

    // forwarding for rs1
    always_comb begin
        case (ctrl_i.rs1_sel)
            fw_ex:   rs1 = fw_i.ex;
            fw_ls:   rs1 = fw_i.ls;
            fw_wb:   rs1 = fw_i.wb;
            default: rs1 = in_i.rs1;
        endcase
    end

    // forwarding for rs2, also the store data
    always_comb begin
        case (ctrl_i.rs2_sel)
            fw_ex:   rs2 = fw_i.ex;
            fw_ls:   rs2 = fw_i.ls;
            fw_wb:   rs2 = fw_i.wb;
            default: rs2 = in_i.rs2;
        endcase
    end

    assign src1 = ctrl_i.src1_pc ? in_i.pc : rs1;

    always_comb begin
        case (ctrl_i.src2_sel)
            src2_imm:  src2 = in_i.imm;
            src2_zero: src2 = '0;
            // link address for jal/jalr
            src2_four: src2 = 32'd4;
            default:   src2 = rs2;
        endcase
    end

    // divide request, only when the stage could otherwise accept
    // muldiv acts on it while idle or done
    assign div_start = valid_i & ctrl_i.md_en & ctrl_i.md_op[2] & ls_addr_ok_i;

    alu u_alu (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .op_i      (ctrl_i.alu_op),
        .md_en_i   (ctrl_i.md_en),
        .md_op_i   (ctrl_i.md_op),
        .start_i   (div_start),
        .src1_i    (src1),
        .src2_i    (src2),
        .res_o     (res_o.alu_res),
        .md_busy_o (md_busy)
    );

    bcu u_bcu (
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .imm_i     (in_i.imm),
        .pc_i      (in_i.pc),
        .funct3_i  (in_i.instr[14:12]),
        .is_jal_i  (ctrl_i.is_jal),
        .is_jalr_i (ctrl_i.is_jalr),
        .is_brc_i  (ctrl_i.is_brc),
        .pc_next_o (res_o.pc_next),
        .is_jump_o (res_o.is_jump)
    );

    assign res_o.rs2_fwd = rs2;
    assign res_o.wren    = (in_i.instr[6:2] == op_store);
    // loads need the full 32-bit encoding, low bits 11
    assign res_o.rden    = (in_i.instr[6:0] == {op_load, 2'b11});

    assign stall_o = md_busy | ~ls_addr_ok_i;

endmodule

// ==== bcu.sv ====
/*
 * Branch control unit.
 * Evaluates the branch condition from funct3 and computes the next
 * pc for jal, jalr and conditional branches.
 */
`timescale 1ns/10ps

module bcu
    import rv_pkg::*;
(
    input  word_t       rs1_i,
    input  word_t       rs2_i,
    input  word_t       imm_i,
    input  word_t       pc_i,
    input  logic [2:0]  funct3_i,
    input  logic        is_jal_i,
    input  logic        is_jalr_i,
    input  logic        is_brc_i,
    output word_t       pc_next_o,
    output logic        is_jump_o
);

    logic  taken;
    word_t jalr_tgt;

    always_comb begin
        case (funct3_i)
            3'b000:  taken = (rs1_i == rs2_i);
            3'b001:  taken = (rs1_i != rs2_i);
            3'b100:  taken = ($signed(rs1_i) < $signed(rs2_i));
            3'b101:  taken = ($signed(rs1_i) >= $signed(rs2_i));
            3'b110:  taken = (rs1_i < rs2_i);
            3'b111:  taken = (rs1_i >= rs2_i);
            // 010/011 are not branches
            default: taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign jalr_tgt = (rs1_i + imm_i) & ~word_t'(1);

    always_comb begin
        if (is_jalr_i) begin
            pc_next_o = jalr_tgt;
        end else if (is_jal_i || (is_brc_i && taken)) begin
            pc_next_o = pc_i + imm_i;
        end else begin
            pc_next_o = pc_i + 32'd4;
        end
    end

    assign is_jump_o = is_jal_i || is_jalr_i || (is_brc_i && taken);

endmodule

// ==== alu.sv ====
/*
 * Integer ALU of the execute stage.
 * Computes the RV32I operation on src1/src2 and hands over to the
 * muldiv unit when md_en_i is set.
 */
`timescale 1ns/10ps

module alu
    import rv_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  alu_op_e op_i,
    input  logic    md_en_i,
    input  md_op_e  md_op_i,
    input  logic    start_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    output word_t   res_o,
    output logic    md_busy_o
);

    word_t      int_res;
    word_t      md_res;
    logic [4:0] shamt;

    // shifts only look at the low 5 bits
    assign shamt = src2_i[4:0];

    always_comb begin
        case (op_i)
            alu_add:    int_res = src1_i + src2_i;
            alu_sub:    int_res = src1_i - src2_i;
            alu_sll:    int_res = src1_i << shamt;
            alu_slt:    int_res = {31'b0, $signed(src1_i) < $signed(src2_i)};
            alu_sltu:   int_res = {31'b0, src1_i < src2_i};
            alu_xor:    int_res = src1_i ^ src2_i;
            alu_srl:    int_res = src1_i >> shamt;
            alu_sra:    int_res = word_t'($signed(src1_i) >>> shamt);
            alu_or:     int_res = src1_i | src2_i;
            alu_and:    int_res = src1_i & src2_i;
            // lui: immediate already shifted by decode
            alu_pass_b: int_res = src2_i;
            default:    int_res = '0;
        endcase
    end

    muldiv u_muldiv (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .op_i     (md_op_i),
        .start_i  (start_i),
        .a_i      (src1_i),
        .b_i      (src2_i),
        .res_o    (md_res),
        .busy_o   (md_busy_o)
    );

    // m extension result overrides the integer path
    assign res_o = md_en_i ? md_res : int_res;

endmodule

// ==== muldiv.sv ====
/*
 * Multiply/divide unit for the M extension.
 * Multiply is a single combinational product; divide is a radix-2
 * restoring divider on magnitudes, one quotient bit per cycle.
 */
`timescale 1ns/10ps

module muldiv
    import rv_pkg::*;
(
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  md_op_e op_i,
    input  logic   start_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output word_t  res_o,
    output logic   busy_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

    div_state_e  state;
    logic [4:0]  cnt;
    word_t       rem_q;
    word_t       quo_q;
    word_t       dvs_q;
    logic        q_neg;
    logic        r_neg;
    logic        b_zero;

    logic        a_signed;
    logic        b_signed;
    logic        a_neg;
    logic        b_neg;
    word_t       a_mag;
    word_t       b_mag;
    logic [65:0] prod;
    word_t       mul_res;
    word_t       div_res;
    logic [32:0] rem_sh;
    logic        ge;

    // mulh, mulhsu, div, rem treat a as signed
    assign a_signed = (op_i == md_mulh) || (op_i == md_mulhsu) ||
                      (op_i == md_div)  || (op_i == md_rem);
    // b only for mulh, div, rem
    assign b_signed = (op_i == md_mulh) || (op_i == md_div) || (op_i == md_rem);

    assign a_neg = a_signed & a_i[31];
    assign b_neg = b_signed & b_i[31];
    assign a_mag = a_neg ? -a_i : a_i;
    assign b_mag = b_neg ? -b_i : b_i;

    // 33-bit sign/zero extension covers all four multiply flavours
    assign prod    = $signed({a_neg, a_i}) * $signed({b_neg, b_i});
    assign mul_res = (op_i == md_mul) ? prod[31:0] : prod[63:32];

    // one restoring step
    assign rem_sh = {rem_q, quo_q[31]};
    assign ge     = rem_sh >= {1'b0, dvs_q};

    // start cycle counts as busy so the stall rises at once
    assign busy_o = (state == st_run) || (state == st_idle && start_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_i) begin
                        state <= st_run;
                        cnt   <= '0;
                    end
                end
                st_run: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    // result leaves once the stage accepts it
                    if (start_i) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == st_idle && start_i) begin
            rem_q  <= '0;
            quo_q  <= a_mag;
            dvs_q  <= b_mag;
            b_zero <= (b_i == '0);
            q_neg  <= a_neg ^ b_neg;
            r_neg  <= a_neg;
        end else if (state == st_run) begin
            rem_q <= ge ? word_t'(rem_sh - {1'b0, dvs_q}) : rem_sh[31:0];
            quo_q <= {quo_q[30:0], ge};
        end
    end

    // divide by zero: magnitude is already all ones, keep it unsigned
    // overflow falls out of the magnitude path on its own
    always_comb begin
        if (op_i == md_rem || op_i == md_remu) begin
            div_res = r_neg ? -rem_q : rem_q;
        end else begin
            div_res = (q_neg && !b_zero) ? -quo_q : quo_q;
        end
    end

    assign res_o = op_i[2] ? div_res : mul_res;

endmodule

// ==== rv_pkg.sv ====
/*
 * Shared types for the RV32IM execute stage and its testbench.
 * Holds word types, operation encodings and the control and result
 * bundles that travel between the pipeline stages.
 */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;

    // alu operation codes, decoded upstream
    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,
        alu_sltu   = 5'd4,
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        // lui result, src2 straight through
        alu_pass_b = 5'd10
    } alu_op_e;

    // same values as the M extension funct3
    typedef enum logic [2:0] {
        md_mul    = 3'd0,
        md_mulh   = 3'd1,
        md_mulhsu = 3'd2,
        md_mulhu  = 3'd3,
        md_div    = 3'd4,
        md_divu   = 3'd5,
        md_rem    = 3'd6,
        md_remu   = 3'd7
    } md_op_e;

    // operand source for rs1 and rs2
    typedef enum logic [1:0] {
        fw_rf = 2'd0,
        fw_ex = 2'd1,
        fw_ls = 2'd2,
        fw_wb = 2'd3
    } fw_sel_e;

    typedef enum logic [1:0] {
        src2_rs2  = 2'd0,
        src2_imm  = 2'd1,
        src2_zero = 2'd2,
        src2_four = 2'd3
    } src2_sel_e;

    // major opcode field, instr[6:2]
    localparam logic [4:0] op_load  = 5'b00000;
    localparam logic [4:0] op_store = 5'b01000;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_pc;
        src2_sel_e src2_sel;
        fw_sel_e   rs1_sel;
        fw_sel_e   rs2_sel;
        logic      is_jal;
        logic      is_jalr;
        logic      is_brc;
        logic      md_en;
        md_op_e    md_op;
    } ex_ctrl_t;

    typedef struct packed {
        word_t  pc;
        instr_t instr;
        word_t  rs1;
        word_t  rs2;
        word_t  imm;
    } ex_in_t;

    // results fed back from later stages
    typedef struct packed {
        word_t ex;
        word_t ls;
        word_t wb;
    } fw_bus_t;

    typedef struct packed {
        word_t alu_res;
        word_t rs2_fwd;
        word_t pc_next;
        logic  is_jump;
        logic  rden;
        logic  wren;
    } ex_res_t;

endpackage
